// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  - logic/rename_pkg.sv
  - logic/spec_rat.sv
  - logic/commit_rat.sv
  - logic/arch_regfile.sv
  - logic/rob_alloc.sv
  - logic/rename_stage.sv
  - target: test
    files:
      - test/rename_tb.sv

// ==== logic/arch_regfile.sv ====
module arch_regfile
    import rename_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic [3:0][AREG_W-1:0] raddr_i,
    output logic [3:0][XLEN-1:0]   rdata_o,
    input  logic [1:0][AREG_W-1:0] waddr_i,
    input  logic [1:0]             we_i,
    input  logic [1:0][XLEN-1:0]   wdata_i
);

    logic [NUM_AREG-1:0][XLEN-1:0] regs_q;
    logic [1:0]                    wr_ok;

    // register 0 is hardwired, drop writes to it
    for (genvar w = 0; w < 2; w++) begin : g_wr_ok
        assign wr_ok[w] = we_i[w] && (waddr_i[w] != '0);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wr_ok[w]) begin
                    regs_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            rdata_o[r] = regs_q[raddr_i[r]];
            // forward retiring data, port 1 last
            for (int w = 0; w < 2; w++) begin
                if (wr_ok[w] && (waddr_i[w] == raddr_i[r])) begin
                    rdata_o[r] = wdata_i[w];
                end
            end
            if (raddr_i[r] == '0) begin
                rdata_o[r] = '0;
            end
        end
    end

endmodule

// ==== logic/commit_rat.sv ====
module commit_rat
    import rename_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   flush_i,
    input  logic [5:0][AREG_W-1:0] raddr_i,
    output rat_entry_t [5:0]       rdata_o,
    input  logic [1:0][AREG_W-1:0] waddr_i,
    input  logic [1:0]             we_i,
    input  rat_entry_t [1:0]       wdata_i
);

    // retired producer per architectural register
    rat_entry_t [NUM_AREG-1:0] map_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            map_q <= '0;
        end else if (flush_i) begin
            map_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (we_i[w]) begin
                    map_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // reads see this cycle's retires
    // later port overrides, same order as the write loop
    always_comb begin
        for (int r = 0; r < 6; r++) begin
            rdata_o[r] = map_q[raddr_i[r]];
            for (int w = 0; w < 2; w++) begin
                if (we_i[w] && (waddr_i[w] == raddr_i[r])) begin
                    rdata_o[r] = wdata_i[w];
                end
            end
        end
    end

endmodule

// ==== logic/rename_pkg.sv ====
package rename_pkg;

    // architectural register file
    localparam int NUM_AREG = 32;
    localparam int AREG_W = 5;

    // reorder buffer
    localparam int ROB_DEPTH = 64;
    localparam int ROB_W = 6;
    // highest occupancy that still lets a pair rename
    localparam int ROB_LIMIT = 60;
    // occupancy counter has to reach ROB_DEPTH itself
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    // datapath
    localparam int XLEN = 32;

    // one RAT slot
    // check toggles on each new producer of a register, so spec and commit
    // entries only match once the newest producer has retired
    typedef struct packed {
        logic             check;
        logic [ROB_W-1:0] rob_id;
    } rat_entry_t;

    // functional unit class, carried through to dispatch
    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_MDU  = 2'd1,
        FU_LSU  = 2'd2,
        FU_NONE = 2'd3
    } fu_type_e;

endpackage

// ==== logic/rename_stage.sv ====
module rename_stage
    import rename_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n_i,
    // decode side
    input  logic                   d_valid_i,
    input  logic [1:0]             d_slot_valid_i,
    input  logic [3:0][AREG_W-1:0] d_src_areg_i,
    input  logic [3:0]             d_src_need_i,
    input  logic [1:0][AREG_W-1:0] d_dst_areg_i,
    input  logic [1:0]             d_w_reg_i,
    input  fu_type_e [1:0]         d_fu_type_i,
    input  logic [XLEN-1:0]        d_pc_i,
    output logic                   d_ready_o,
    // dispatch side
    output logic                   p_valid_o,
    input  logic                   p_ready_i,
    output logic [1:0]             p_slot_valid_o,
    output logic [3:0][ROB_W-1:0]  p_src_robid_o,
    output logic [3:0][XLEN-1:0]   p_src_data_o,
    output logic [3:0]             p_src_ready_o,
    output logic [1:0][ROB_W-1:0]  p_dst_robid_o,
    output logic [1:0]             p_dst_check_o,
    output logic [1:0][AREG_W-1:0] p_dst_areg_o,
    output logic [1:0]             p_w_reg_o,
    output fu_type_e [1:0]         p_fu_type_o,
    output logic [XLEN-1:0]        p_pc_o,
    // retire side
    input  logic [1:0]             c_retire_i,
    input  logic [1:0]             c_w_valid_i,
    input  logic [1:0][AREG_W-1:0] c_areg_i,
    input  logic [1:0][ROB_W-1:0]  c_rob_id_i,
    input  logic [1:0]             c_w_check_i,
    input  logic [1:0][XLEN-1:0]   c_data_i,
    input  logic                   c_flush_i
);

    logic                   rob_available;
    logic [ROB_W-1:0]       base_id;
    logic                   accept;
    logic [1:0]             issue;
    logic [1:0][ROB_W-1:0]  dst_id;
    logic [1:0]             spec_we;
    rat_entry_t [1:0]       spec_new;
    rat_entry_t [3:0]       spec_src;
    logic [5:0][AREG_W-1:0] commit_raddr;
    rat_entry_t [5:0]       commit_rd;
    logic [1:0]             commit_we;
    rat_entry_t [1:0]       commit_new;
    logic [3:0][XLEN-1:0]   arf_src_data;
    logic [3:0][ROB_W-1:0]  src_id;
    logic [3:0]             src_ready;

    assign d_ready_o = rob_available && !c_flush_i && (!p_valid_o || p_ready_i);
    assign accept    = d_valid_i && d_ready_o;
    assign issue     = d_slot_valid_i & {2{accept}};

    // slot 1 takes the next id only when slot 0 used one
    assign dst_id[0] = base_id;
    assign dst_id[1] = base_id + ROB_W'(issue[0]);

    // commit RAT ports 0..3 serve sources, 4..5 the destinations
    for (genvar s = 0; s < 4; s++) begin : g_src_addr
        assign commit_raddr[s] = d_src_areg_i[s];
    end

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign commit_raddr[4+i]  = d_dst_areg_i[i];
        assign spec_we[i]         = issue[i] && d_w_reg_i[i] && (d_dst_areg_i[i] != '0);
        assign spec_new[i].rob_id = dst_id[i];
        assign spec_new[i].check  = ~commit_rd[4+i].check;

        assign commit_we[i]         = c_retire_i[i] && c_w_valid_i[i] && (c_areg_i[i] != '0);
        assign commit_new[i].rob_id = c_rob_id_i[i];
        assign commit_new[i].check  = c_w_check_i[i];
    end

    always_comb begin
        for (int s = 0; s < 4; s++) begin
            src_id[s]    = spec_src[s].rob_id;
            // producer retired when both maps agree, value is in the ARF
            src_ready[s] = !d_src_need_i[s] || (spec_src[s] == commit_rd[s]);
            // in-pair dependency on slot 0
            if ((s >= 2) && spec_we[0] && (d_src_areg_i[s] == d_dst_areg_i[0])) begin
                src_id[s]    = dst_id[0];
                src_ready[s] = 1'b0;
            end
        end
    end

    rob_alloc u_rob_alloc (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (c_flush_i),
        .issue_i     (issue),
        .retire_i    (c_retire_i),
        .base_id_o   (base_id),
        .available_o (rob_available)
    );

    spec_rat u_spec_rat (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (c_flush_i),
        .raddr_i  (d_src_areg_i),
        .rdata_o  (spec_src),
        .waddr_i  (d_dst_areg_i),
        .we_i     (spec_we),
        .wdata_i  (spec_new)
    );

    commit_rat u_commit_rat (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (c_flush_i),
        .raddr_i  (commit_raddr),
        .rdata_o  (commit_rd),
        .waddr_i  (c_areg_i),
        .we_i     (commit_we),
        .wdata_i  (commit_new)
    );

    arch_regfile u_arch_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr_i  (d_src_areg_i),
        .rdata_o  (arf_src_data),
        .waddr_i  (c_areg_i),
        .we_i     (commit_we),
        .wdata_i  (c_data_i)
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            p_valid_o <= 1'b0;
        end else if (c_flush_i) begin
            p_valid_o <= 1'b0;
        end else if (accept) begin
            p_valid_o <= 1'b1;
        end else if (p_ready_i) begin
            p_valid_o <= 1'b0;
        end
    end

    // payload only moves on acceptance, held under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            p_slot_valid_o <= d_slot_valid_i;
            p_src_robid_o  <= src_id;
            p_src_data_o   <= arf_src_data;
            p_src_ready_o  <= src_ready;
            p_dst_robid_o  <= dst_id;
            p_dst_check_o  <= {spec_new[1].check, spec_new[0].check};
            p_dst_areg_o   <= d_dst_areg_i;
            p_w_reg_o      <= d_w_reg_i;
            p_fu_type_o    <= d_fu_type_i;
            p_pc_o         <= d_pc_i;
        end
    end

endmodule

// ==== logic/rob_alloc.sv ====
module rob_alloc
    import rename_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             flush_i,
    input  logic [1:0]       issue_i,
    input  logic [1:0]       retire_i,
    output logic [ROB_W-1:0] base_id_o,
    output logic             available_o
);

    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic [ROB_W-1:0] ptr_q;
    logic [ROB_W-1:0] ptr_d;
    logic             available_q;

    assign count_d = count_q + CNT_W'(issue_i[0]) + CNT_W'(issue_i[1])
                   - CNT_W'(retire_i[0]) - CNT_W'(retire_i[1]);

    // ROB_DEPTH is a power of two, pointer wraps on its own
    assign ptr_d = ptr_q + ROB_W'(issue_i[0]) + ROB_W'(issue_i[1]);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q     <= '0;
            ptr_q       <= '0;
            available_q <= 1'b1;
        end else if (flush_i) begin
            count_q     <= '0;
            ptr_q       <= '0;
            available_q <= 1'b1;
        end else begin
            count_q     <= count_d;
            ptr_q       <= ptr_d;
            // one cycle behind the count, ROB_LIMIT leaves room for the lag
            available_q <= (count_q <= CNT_W'(ROB_LIMIT));
        end
    end

    assign base_id_o   = ptr_q;
    assign available_o = available_q;

endmodule

// ==== logic/spec_rat.sv ====
module spec_rat
    import rename_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   flush_i,
    input  logic [3:0][AREG_W-1:0] raddr_i,
    output rat_entry_t [3:0]       rdata_o,
    input  logic [1:0][AREG_W-1:0] waddr_i,
    input  logic [1:0]             we_i,
    input  rat_entry_t [1:0]       wdata_i
);

    // newest in-flight producer per architectural register
    rat_entry_t [NUM_AREG-1:0] map_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            map_q <= '0;
        end else if (flush_i) begin
            map_q <= '0;
        end else begin
            // port 1 is written last and wins on a shared register
            for (int w = 0; w < 2; w++) begin
                if (we_i[w]) begin
                    map_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // no forwarding here, the rename stage bypasses inside the pair itself
    for (genvar r = 0; r < 4; r++) begin : g_read
        assign rdata_o[r] = map_q[raddr_i[r]];
    end

endmodule

// ==== tb.f ====
logic/rename_pkg.sv
logic/spec_rat.sv
logic/commit_rat.sv
logic/arch_regfile.sv
logic/rob_alloc.sv
logic/rename_stage.sv
test/rename_tb.sv

// ==== test/rename_tb.sv ====
module rename_tb
    import rename_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // rough length of all tests in cycles
    localparam int STIM_CYCLES = 1000;
    localparam int MAX_CYCLES  = 4 * STIM_CYCLES;
    localparam int NUM_PAIRS   = 300;

    typedef struct packed {
        logic [1:0]             slot_valid;
        logic [3:0][ROB_W-1:0]  src_robid;
        logic [3:0][XLEN-1:0]   src_data;
        logic [3:0]             src_ready;
        logic [1:0][ROB_W-1:0]  dst_robid;
        logic [1:0]             dst_check;
        logic [1:0]             dst_we;
        logic [1:0][AREG_W-1:0] dst_areg;
        logic [1:0]             w_reg;
        logic [1:0][1:0]        fu;
        logic [XLEN-1:0]        pc;
    } pair_t;

    // one in-flight instruction, oldest first
    typedef struct packed {
        logic              w_valid;
        logic [AREG_W-1:0] areg;
        logic [ROB_W-1:0]  rob_id;
        logic              check;
    } rob_ent_t;

    logic                   clk;
    logic                   arst_n_i;
    logic                   d_valid_i;
    logic [1:0]             d_slot_valid_i;
    logic [3:0][AREG_W-1:0] d_src_areg_i;
    logic [3:0]             d_src_need_i;
    logic [1:0][AREG_W-1:0] d_dst_areg_i;
    logic [1:0]             d_w_reg_i;
    fu_type_e [1:0]         d_fu_type_i;
    logic [XLEN-1:0]        d_pc_i;
    logic                   d_ready_o;
    logic                   p_valid_o;
    logic                   p_ready_i;
    logic [1:0]             p_slot_valid_o;
    logic [3:0][ROB_W-1:0]  p_src_robid_o;
    logic [3:0][XLEN-1:0]   p_src_data_o;
    logic [3:0]             p_src_ready_o;
    logic [1:0][ROB_W-1:0]  p_dst_robid_o;
    logic [1:0]             p_dst_check_o;
    logic [1:0][AREG_W-1:0] p_dst_areg_o;
    logic [1:0]             p_w_reg_o;
    fu_type_e [1:0]         p_fu_type_o;
    logic [XLEN-1:0]        p_pc_o;
    logic [1:0]             c_retire_i;
    logic [1:0]             c_w_valid_i;
    logic [1:0][AREG_W-1:0] c_areg_i;
    logic [1:0][ROB_W-1:0]  c_rob_id_i;
    logic [1:0]             c_w_check_i;
    logic [1:0][XLEN-1:0]   c_data_i;
    logic                   c_flush_i;

    // reference state of the rename stage
    rat_entry_t      m_spec [NUM_AREG];
    rat_entry_t      m_commit [NUM_AREG];
    logic [XLEN-1:0] m_arf [NUM_AREG];
    int              m_ptr;
    int              m_count;
    logic            m_avail;
    logic            m_pvalid;
    rob_ent_t        rob_q [$];
    pair_t           exp_q [$];

    integer seed;
    int     errors;
    int     err_mark;
    int     n_tests;
    int     n_accept;
    int     n_xfer;
    int     stall_left;
    int     cycle_cnt;
    logic   valid_on;
    logic   retire_on;
    logic   ready_rand;
    logic   flush_req;

    rename_stage u_rename_stage (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic flag_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        errors++;
        $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
    endtask

    task automatic clear_rats();
        for (int a = 0; a < NUM_AREG; a++) begin
            m_spec[a]   = '0;
            m_commit[a] = '0;
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("test %s finished at %0d ns with %0d errors", name, $time, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic check_pair(input pair_t e);
        if (p_slot_valid_o !== e.slot_valid)
            flag_mismatch("slot valid", p_slot_valid_o, e.slot_valid);
        if (p_dst_areg_o !== e.dst_areg)
            flag_mismatch("dst areg", p_dst_areg_o, e.dst_areg);
        if (p_w_reg_o !== e.w_reg)
            flag_mismatch("w_reg", p_w_reg_o, e.w_reg);
        if (p_fu_type_o !== e.fu)
            flag_mismatch("fu type", p_fu_type_o, e.fu);
        if (p_pc_o !== e.pc)
            flag_mismatch("pc", p_pc_o, e.pc);
        for (int i = 0; i < 2; i++) begin
            if (e.slot_valid[i] && (p_dst_robid_o[i] !== e.dst_robid[i]))
                flag_mismatch($sformatf("slot %0d rob id", i), p_dst_robid_o[i], e.dst_robid[i]);
            if (e.dst_we[i] && (p_dst_check_o[i] !== e.dst_check[i]))
                flag_mismatch($sformatf("slot %0d check", i), p_dst_check_o[i], e.dst_check[i]);
        end
        for (int s = 0; s < 4; s++) begin
            if (!e.slot_valid[s/2])
                continue;
            if (p_src_ready_o[s] !== e.src_ready[s])
                flag_mismatch($sformatf("src %0d ready", s), p_src_ready_o[s], e.src_ready[s]);
            else if (e.src_ready[s] && (p_src_data_o[s] !== e.src_data[s]))
                flag_mismatch($sformatf("src %0d data", s), p_src_data_o[s], e.src_data[s]);
            else if (!e.src_ready[s] && (p_src_robid_o[s] !== e.src_robid[s]))
                flag_mismatch($sformatf("src %0d rob id", s), p_src_robid_o[s], e.src_robid[s]);
        end
    endtask

    task automatic run_cycle();
        rat_entry_t      cr [NUM_AREG];
        logic [XLEN-1:0] av [NUM_AREG];
        pair_t           e;
        logic            exp_ready;
        logic            accept;
        int              n_ret;
        int              n_iss;
        @(posedge clk);
        #2;
        n_ret = (retire_on && !flush_req) ? rand_below(3) : 0;
        if (n_ret > rob_q.size())
            n_ret = rob_q.size();
        for (int i = 0; i < 2; i++) begin
            if (i < n_ret) begin
                c_w_valid_i[i] = rob_q[i].w_valid;
                c_areg_i[i]    = rob_q[i].areg;
                c_rob_id_i[i]  = rob_q[i].rob_id;
                c_w_check_i[i] = rob_q[i].check;
            end else begin
                // idle retire slot carries junk
                c_w_valid_i[i] = rand_below(2);
                c_areg_i[i]    = rand_below(NUM_AREG);
                c_rob_id_i[i]  = rand_below(ROB_DEPTH);
                c_w_check_i[i] = rand_below(2);
            end
            c_retire_i[i]   = (i < n_ret);
            c_data_i[i]     = $random(seed);
            d_dst_areg_i[i] = rand_below(8);
            d_fu_type_i[i]  = fu_type_e'(rand_below(4));
        end
        // mostly low registers so producers collide often
        for (int s = 0; s < 4; s++) begin
            d_src_areg_i[s] = (rand_below(8) == 0) ? rand_below(NUM_AREG) : rand_below(8);
        end
        d_valid_i      = valid_on && (rand_below(4) != 0);
        d_slot_valid_i = rand_below(4);
        d_src_need_i   = rand_below(16);
        d_w_reg_i      = rand_below(4);
        d_pc_i         = $random(seed);
        c_flush_i      = flush_req;
        if (!ready_rand)
            stall_left = 0;
        else if (stall_left > 0)
            stall_left--;
        else if (rand_below(8) == 0)
            stall_left = 1 + rand_below(6);
        p_ready_i = (stall_left == 0) && !flush_req;

        #10;
        exp_ready = m_avail && !flush_req && (!m_pvalid || p_ready_i);
        if (d_ready_o !== exp_ready)
            flag_mismatch("d_ready_o", d_ready_o, exp_ready);
        if (p_valid_o !== m_pvalid)
            flag_mismatch("p_valid_o", p_valid_o, m_pvalid);
        if (m_pvalid && p_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("dispatch handshake at %0d ns with no renamed pair pending", $time);
            end else begin
                e = exp_q.pop_front();
                check_pair(e);
                n_xfer++;
            end
        end

        // commit map and register values with this cycle's retires applied
        for (int a = 0; a < NUM_AREG; a++) begin
            cr[a] = m_commit[a];
            av[a] = m_arf[a];
        end
        for (int i = 0; i < n_ret; i++) begin
            if (c_w_valid_i[i] && (c_areg_i[i] != 0)) begin
                cr[c_areg_i[i]] = {c_w_check_i[i], c_rob_id_i[i]};
                av[c_areg_i[i]] = c_data_i[i];
            end
        end
        accept = d_valid_i && exp_ready;
        n_iss  = accept ? int'(d_slot_valid_i[0]) + int'(d_slot_valid_i[1]) : 0;
        if (accept) begin
            e            = '0;
            e.slot_valid = d_slot_valid_i;
            e.dst_areg   = d_dst_areg_i;
            e.w_reg      = d_w_reg_i;
            e.fu         = d_fu_type_i;
            e.pc         = d_pc_i;
            for (int i = 0; i < 2; i++) begin
                e.dst_robid[i] = (i == 0) ? m_ptr : m_ptr + int'(d_slot_valid_i[0]);
                e.dst_check[i] = ~cr[d_dst_areg_i[i]].check;
                e.dst_we[i]    = d_slot_valid_i[i] && d_w_reg_i[i] && (d_dst_areg_i[i] != 0);
            end
            for (int s = 0; s < 4; s++) begin
                e.src_data[s] = av[d_src_areg_i[s]];
                if ((s >= 2) && e.dst_we[0] && (d_src_areg_i[s] == d_dst_areg_i[0])) begin
                    e.src_robid[s] = e.dst_robid[0];
                    e.src_ready[s] = 1'b0;
                end else begin
                    e.src_robid[s] = m_spec[d_src_areg_i[s]].rob_id;
                    e.src_ready[s] = !d_src_need_i[s] ||
                                     (m_spec[d_src_areg_i[s]] == cr[d_src_areg_i[s]]);
                end
            end
            exp_q.push_back(e);
            n_accept++;
        end

        // state after the coming edge
        if (flush_req) begin
            clear_rats();
            m_ptr    = 0;
            m_count  = 0;
            m_avail  = 1'b1;
            m_pvalid = 1'b0;
            rob_q.delete();
            exp_q.delete();
        end else begin
            m_avail  = (m_count <= ROB_LIMIT);
            m_count  = m_count + n_iss - n_ret;
            m_pvalid = accept || (m_pvalid && !p_ready_i);
            for (int a = 0; a < NUM_AREG; a++) begin
                m_commit[a] = cr[a];
                m_arf[a]    = av[a];
            end
            for (int i = 0; i < n_ret; i++) begin
                void'(rob_q.pop_front());
            end
            for (int i = 0; i < 2; i++) begin
                if (accept && e.dst_we[i])
                    m_spec[d_dst_areg_i[i]] = {e.dst_check[i], e.dst_robid[i]};
                if (accept && d_slot_valid_i[i])
                    rob_q.push_back({d_w_reg_i[i], d_dst_areg_i[i], e.dst_robid[i],
                                     e.dst_check[i]});
            end
            m_ptr = (m_ptr + n_iss) % ROB_DEPTH;
        end
    endtask

    initial begin
        seed           = 28249;
        errors         = 0;
        err_mark       = 0;
        n_tests        = 0;
        n_accept       = 0;
        n_xfer         = 0;
        stall_left     = 0;
        arst_n_i       = 1'b0;
        d_valid_i      = 1'b0;
        d_slot_valid_i = '0;
        d_src_areg_i   = '0;
        d_src_need_i   = '0;
        d_dst_areg_i   = '0;
        d_w_reg_i      = '0;
        d_fu_type_i[0] = FU_NONE;
        d_fu_type_i[1] = FU_NONE;
        d_pc_i         = '0;
        p_ready_i      = 1'b0;
        c_retire_i     = '0;
        c_w_valid_i    = '0;
        c_areg_i       = '0;
        c_rob_id_i     = '0;
        c_w_check_i    = '0;
        c_data_i       = '0;
        c_flush_i      = 1'b0;
        flush_req      = 1'b0;
        clear_rats();
        for (int a = 0; a < NUM_AREG; a++) begin
            m_arf[a] = '0;
        end
        m_ptr    = 0;
        m_count  = 0;
        m_avail  = 1'b1;
        m_pvalid = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        arst_n_i = 1'b1;

        // ids, mapping, readiness and back-pressure under random traffic
        valid_on   = 1'b1;
        retire_on  = 1'b1;
        ready_rand = 1'b1;
        while (n_accept < NUM_PAIRS) begin
            run_cycle();
        end
        end_test("random_rename");

        // fill the ROB with retires held back
        retire_on  = 1'b0;
        ready_rand = 1'b0;
        while (m_count <= ROB_LIMIT) begin
            run_cycle();
        end
        // available flag lags the count by one edge
        run_cycle();
        run_cycle();
        if (d_ready_o !== 1'b0)
            flag_mismatch("d_ready_o with the ROB full", d_ready_o, 1'b0);
        repeat (5) run_cycle();
        retire_on = 1'b1;
        while (d_ready_o !== 1'b1) begin
            run_cycle();
        end
        end_test("rob_full");

        ready_rand = 1'b1;
        repeat (20) run_cycle();
        while (!m_pvalid) begin
            run_cycle();
        end
        flush_req = 1'b1;
        run_cycle();
        flush_req = 1'b0;
        run_cycle();
        if (p_valid_o !== 1'b0)
            flag_mismatch("p_valid_o after flush", p_valid_o, 1'b0);
        repeat (60) run_cycle();
        end_test("flush");

        valid_on   = 1'b0;
        ready_rand = 1'b0;
        while ((rob_q.size() != 0) || (exp_q.size() != 0)) begin
            run_cycle();
        end
        end_test("drain");

        $display("%0d tests, %0d pairs renamed, %0d pairs dispatched, %0d errors",
                 n_tests, n_accept, n_xfer, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
